// File: all.f
+incdir+.
udp_echo_pkg.sv
udp_port_filter.sv
udp_payload_fifo.sv
udp_reply_builder.sv
udp_echo_core.sv
udp_echo_assert.sv
udp_echo_tb.sv

// File: udp_echo_assert.sv
/*
 * Reply stream checks
 * Handshake stability and reset behaviour of the reply header and payload
 */

`timescale 1ns/1ps
`default_nettype none

module udp_echo_assert (
    input wire                              clk,
    input wire                              rst,
    input wire                              m_hdr_valid,
    input wire                              m_hdr_ready,
    input wire udp_echo_pkg::ip_addr_t      m_ip_dest_ip,
    input wire udp_echo_pkg::udp_port_t     m_source_port,
    input wire udp_echo_pkg::udp_port_t     m_dest_port,
    input wire udp_echo_pkg::udp_len_t      m_length,
    input wire                              m_payload_tvalid,
    input wire                              m_payload_tready,
    input wire udp_echo_pkg::payload_word_t m_payload_tdata,
    input wire udp_echo_pkg::payload_keep_t m_payload_tkeep,
    input wire                              m_payload_tlast,
    input wire                              m_payload_tuser
);
    int fail_count = 0;

    // A held reply header keeps its fields
    property hdr_held;
        @(posedge clk) disable iff (rst)
        m_hdr_valid && !m_hdr_ready |=> m_hdr_valid && $stable(m_ip_dest_ip) &&
            $stable(m_source_port) && $stable(m_dest_port) && $stable(m_length);
    endproperty

    property payload_held;
        @(posedge clk) disable iff (rst)
        m_payload_tvalid && !m_payload_tready |=> m_payload_tvalid &&
            $stable(m_payload_tdata) && $stable(m_payload_tkeep) &&
            $stable(m_payload_tlast) && $stable(m_payload_tuser);
    endproperty

    property quiet_after_reset;
        @(posedge clk) $fell(rst) |-> !m_hdr_valid && !m_payload_tvalid;
    endproperty

    assert property (hdr_held) else begin
        $error("reply header dropped or changed before it was accepted");
        fail_count++;
    end

    assert property (payload_held) else begin
        $error("reply payload word dropped or changed before it was accepted");
        fail_count++;
    end

    assert property (quiet_after_reset) else begin
        $error("reply valid high in the cycle after reset");
        fail_count++;
    end

endmodule

bind udp_echo_core udp_echo_assert udp_echo_assert_inst (
    .clk(clk),
    .rst(rst),
    .m_hdr_valid(m_hdr_valid),
    .m_hdr_ready(m_hdr_ready),
    .m_ip_dest_ip(m_ip_dest_ip),
    .m_source_port(m_source_port),
    .m_dest_port(m_dest_port),
    .m_length(m_length),
    .m_payload_tvalid(m_payload_tvalid),
    .m_payload_tready(m_payload_tready),
    .m_payload_tdata(m_payload_tdata),
    .m_payload_tkeep(m_payload_tkeep),
    .m_payload_tlast(m_payload_tlast),
    .m_payload_tuser(m_payload_tuser)
);

`default_nettype wire

// File: udp_echo_cfg.svh
/*
 * UDP echo engine configuration
 * Echo port, payload word layout and default FIFO sizing
 */

`ifndef UDP_ECHO_CFG_SVH
`define UDP_ECHO_CFG_SVH

// Destination port answered by the engine
`define UDP_ECHO_PORT 1234

// Payload word and its byte enables
`define UDP_ECHO_DATA_W 64
`define UDP_ECHO_KEEP_W 8

// Payload FIFO depth in words, power of two
`define UDP_ECHO_FIFO_DEPTH 16

`endif

// File: udp_echo_core.sv
/*
 * UDP echo engine top level
 * Port filter, payload FIFO and reply builder between the UDP stacks
 */

`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_cfg.svh"

module udp_echo_core (
    input  wire                              clk,
    input  wire                              rst,
    // Receive side
    input  wire                              s_hdr_valid,
    output logic                             s_hdr_ready,
    input  wire udp_echo_pkg::ip_addr_t      s_ip_source_ip,
    input  wire udp_echo_pkg::udp_port_t     s_source_port,
    input  wire udp_echo_pkg::udp_port_t     s_dest_port,
    input  wire udp_echo_pkg::udp_len_t      s_length,
    input  wire udp_echo_pkg::payload_word_t s_payload_tdata,
    input  wire udp_echo_pkg::payload_keep_t s_payload_tkeep,
    input  wire                              s_payload_tvalid,
    output logic                             s_payload_tready,
    input  wire                              s_payload_tlast,
    input  wire                              s_payload_tuser,
    // Transmit side
    output logic                             m_hdr_valid,
    input  wire                              m_hdr_ready,
    output udp_echo_pkg::ip_addr_t           m_ip_dest_ip,
    output udp_echo_pkg::udp_port_t          m_source_port,
    output udp_echo_pkg::udp_port_t          m_dest_port,
    output udp_echo_pkg::udp_len_t           m_length,
    output udp_echo_pkg::payload_word_t      m_payload_tdata,
    output udp_echo_pkg::payload_keep_t      m_payload_tkeep,
    output logic                             m_payload_tvalid,
    input  wire                              m_payload_tready,
    output logic                             m_payload_tlast,
    output logic                             m_payload_tuser,
    output udp_echo_pkg::led_t               led
);
    import udp_echo_pkg::*;

    // Filter to builder
    logic      reply_req;
    logic      reply_ack;
    ip_addr_t  reply_ip_dest_ip;
    udp_port_t reply_source_port;
    udp_port_t reply_dest_port;
    udp_len_t  reply_length;

    // Filter to FIFO
    logic          wr_valid;
    logic          wr_ready;
    payload_word_t wr_data;
    payload_keep_t wr_keep;
    logic          wr_last;
    logic          wr_user;

    udp_port_filter udp_port_filter_inst (
        .clk(clk), .rst(rst),
        .s_hdr_valid(s_hdr_valid), .s_hdr_ready(s_hdr_ready),
        .s_ip_source_ip(s_ip_source_ip), .s_source_port(s_source_port),
        .s_dest_port(s_dest_port), .s_length(s_length),
        .s_payload_tdata(s_payload_tdata), .s_payload_tkeep(s_payload_tkeep),
        .s_payload_tvalid(s_payload_tvalid), .s_payload_tready(s_payload_tready),
        .s_payload_tlast(s_payload_tlast), .s_payload_tuser(s_payload_tuser),
        .reply_req(reply_req), .reply_ack(reply_ack),
        .reply_ip_dest_ip(reply_ip_dest_ip), .reply_source_port(reply_source_port),
        .reply_dest_port(reply_dest_port), .reply_length(reply_length),
        .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_data(wr_data),
        .wr_keep(wr_keep), .wr_last(wr_last), .wr_user(wr_user)
    );

    udp_payload_fifo #(
        .DEPTH(`UDP_ECHO_FIFO_DEPTH)
    ) udp_payload_fifo_inst (
        .clk(clk), .rst(rst),
        .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_data(wr_data),
        .wr_keep(wr_keep), .wr_last(wr_last), .wr_user(wr_user),
        .m_payload_tdata(m_payload_tdata), .m_payload_tkeep(m_payload_tkeep),
        .m_payload_tvalid(m_payload_tvalid), .m_payload_tready(m_payload_tready),
        .m_payload_tlast(m_payload_tlast), .m_payload_tuser(m_payload_tuser)
    );

    udp_reply_builder udp_reply_builder_inst (
        .clk(clk), .rst(rst),
        .reply_req(reply_req), .reply_ack(reply_ack),
        .reply_ip_dest_ip(reply_ip_dest_ip), .reply_source_port(reply_source_port),
        .reply_dest_port(reply_dest_port), .reply_length(reply_length),
        .m_hdr_valid(m_hdr_valid), .m_hdr_ready(m_hdr_ready),
        .m_ip_dest_ip(m_ip_dest_ip), .m_source_port(m_source_port),
        .m_dest_port(m_dest_port), .m_length(m_length),
        .m_payload_tvalid(m_payload_tvalid), .m_payload_tready(m_payload_tready),
        .m_payload_tlast(m_payload_tlast), .m_payload_tdata(m_payload_tdata),
        .led(led)
    );

endmodule

`default_nettype wire

// File: udp_echo_pkg.sv
/*
 * UDP echo engine shared types
 * Header field and payload word types used across the blocks
 */

`default_nettype none

package udp_echo_pkg;

    `include "udp_echo_cfg.svh"

    // UDP header fields
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // IPv4 address of the peer
    typedef logic [31:0] ip_addr_t;

    // Payload beat
    typedef logic [`UDP_ECHO_DATA_W-1:0] payload_word_t;
    typedef logic [`UDP_ECHO_KEEP_W-1:0] payload_keep_t;

    // Status display
    typedef logic [7:0] led_t;

endpackage

`default_nettype wire

// File: udp_echo_tb.sv
/*
 * UDP echo engine testbench
 * Table of datagrams driven through the core, with a random back-pressure
 * sink that checks reply headers, payload and the LED byte
 */

`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_cfg.svh"

module udp_echo_tb;
    import udp_echo_pkg::*;

    localparam int ROWS        = 10;
    localparam int CYCLE_LIMIT = 40 * ROWS + 200;

    logic          clk;
    logic          rst;
    logic          s_hdr_valid;
    logic          s_hdr_ready;
    ip_addr_t      s_ip_source_ip;
    udp_port_t     s_source_port;
    udp_port_t     s_dest_port;
    udp_len_t      s_length;
    payload_word_t s_payload_tdata;
    payload_keep_t s_payload_tkeep;
    logic          s_payload_tvalid;
    logic          s_payload_tready;
    logic          s_payload_tlast;
    logic          s_payload_tuser;
    logic          m_hdr_valid;
    logic          m_hdr_ready;
    ip_addr_t      m_ip_dest_ip;
    udp_port_t     m_source_port;
    udp_port_t     m_dest_port;
    udp_len_t      m_length;
    payload_word_t m_payload_tdata;
    payload_keep_t m_payload_tkeep;
    logic          m_payload_tvalid;
    logic          m_payload_tready;
    logic          m_payload_tlast;
    logic          m_payload_tuser;
    led_t          led;

    // Stimulus table with the expected match decision in row_echo
    udp_port_t     row_dest  [ROWS];
    udp_port_t     row_src   [ROWS];
    ip_addr_t      row_ip    [ROWS];
    udp_len_t      row_len   [ROWS];
    int            row_beats [ROWS];
    payload_keep_t row_keep  [ROWS];
    logic          row_echo  [ROWS];

    // Scoreboard queues
    ip_addr_t      exp_ip    [$];
    udp_port_t     exp_sport [$];
    udp_port_t     exp_dport [$];
    udp_len_t      exp_len   [$];
    payload_word_t exp_data  [$];
    payload_keep_t exp_keep  [$];
    logic          exp_last  [$];
    logic          exp_user  [$];

    int errors;
    int cycles;

    // Set once a matched beat is stalled by a full payload FIFO
    logic fifo_full_seen;

    udp_echo_core udp_echo_core_inst (
        .clk(clk), .rst(rst),
        .s_hdr_valid(s_hdr_valid), .s_hdr_ready(s_hdr_ready),
        .s_ip_source_ip(s_ip_source_ip), .s_source_port(s_source_port),
        .s_dest_port(s_dest_port), .s_length(s_length),
        .s_payload_tdata(s_payload_tdata), .s_payload_tkeep(s_payload_tkeep),
        .s_payload_tvalid(s_payload_tvalid), .s_payload_tready(s_payload_tready),
        .s_payload_tlast(s_payload_tlast), .s_payload_tuser(s_payload_tuser),
        .m_hdr_valid(m_hdr_valid), .m_hdr_ready(m_hdr_ready),
        .m_ip_dest_ip(m_ip_dest_ip), .m_source_port(m_source_port),
        .m_dest_port(m_dest_port), .m_length(m_length),
        .m_payload_tdata(m_payload_tdata), .m_payload_tkeep(m_payload_tkeep),
        .m_payload_tvalid(m_payload_tvalid), .m_payload_tready(m_payload_tready),
        .m_payload_tlast(m_payload_tlast), .m_payload_tuser(m_payload_tuser),
        .led(led)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic set_row(input int i, input int dest, input int src, input logic [31:0] ip,
                           input int len, input int beats, input logic [7:0] keep,
                           input logic echo);
        row_dest[i]  = udp_port_t'(dest);
        row_src[i]   = udp_port_t'(src);
        row_ip[i]    = ip;
        row_len[i]   = udp_len_t'(len);
        row_beats[i] = beats;
        row_keep[i]  = keep;
        row_echo[i]  = echo;
    endtask

    task automatic load_table();
        set_row(0, `UDP_ECHO_PORT,     40000, 32'h0a00_0001, 12, 1, 8'h0f, 1'b1);
        set_row(1, `UDP_ECHO_PORT - 1, 40001, 32'h0a00_0002, 32, 3, 8'hff, 1'b0);
        set_row(2, `UDP_ECHO_PORT,     40002, 32'hc0a8_0105, 54, 6, 8'h3f, 1'b1);
        set_row(3, `UDP_ECHO_PORT + 1, 53,    32'hc0a8_0106, 17, 2, 8'h01, 1'b0);
        set_row(4, `UDP_ECHO_PORT,     1234,  32'hac10_0001, 40, 4, 8'hff, 1'b1);
        set_row(5, 80,                 1234,  32'hac10_0002, 43, 5, 8'h07, 1'b0);
        set_row(6, `UDP_ECHO_PORT,     65535, 32'h7f00_0001, 23, 2, 8'h7f, 1'b1);
        set_row(7, `UDP_ECHO_PORT,     7,     32'h0a0a_0a0a, 56, 6, 8'hff, 1'b1);
        set_row(8, 0,                  1234,  32'hffff_ffff, 16, 1, 8'hff, 1'b0);
        set_row(9, `UDP_ECHO_PORT,     4321,  32'h0102_0304, 26, 3, 8'h03, 1'b1);
    endtask

    task automatic check_outputs_idle(input string when_txt);
        if (m_hdr_valid !== 1'b0 || m_payload_tvalid !== 1'b0 || led !== 8'h00) begin
            errors++;
            $display("Mismatch at %0t: outputs not idle %s (hdr %b, payload %b, led %h)",
                     $time, when_txt, m_hdr_valid, m_payload_tvalid, led);
        end
    endtask

    task automatic send_header(input int i);
        logic taken;
        taken          = 1'b0;
        s_hdr_valid    = 1'b1;
        s_ip_source_ip = row_ip[i];
        s_source_port  = row_src[i];
        s_dest_port    = row_dest[i];
        s_length       = row_len[i];
        // Ports swap and the sender becomes the destination
        if (row_echo[i]) begin
            exp_ip.push_back(row_ip[i]);
            exp_sport.push_back(row_dest[i]);
            exp_dport.push_back(row_src[i]);
            exp_len.push_back(row_len[i]);
        end
        while (!taken) begin
            @(negedge clk);
            taken = s_hdr_ready;
            @(posedge clk);
            #1;
        end
        s_hdr_valid = 1'b0;
    endtask

    task automatic send_payload(input int i);
        int   b;
        logic taken;
        for (b = 0; b < row_beats[i]; b++) begin
            // Occasional idle cycle on the input stream
            if ($urandom % 5 == 0) begin
                s_payload_tvalid = 1'b0;
                @(posedge clk);
                #1;
            end
            s_payload_tvalid = 1'b1;
            s_payload_tdata  = {$urandom, $urandom};
            s_payload_tlast  = (b == row_beats[i] - 1);
            s_payload_tkeep  = s_payload_tlast ? row_keep[i] : {`UDP_ECHO_KEEP_W{1'b1}};
            s_payload_tuser  = ($urandom % 8 == 0);
            if (row_echo[i]) begin
                exp_data.push_back(s_payload_tdata);
                exp_keep.push_back(s_payload_tkeep);
                exp_last.push_back(s_payload_tlast);
                exp_user.push_back(s_payload_tuser);
            end
            taken = 1'b0;
            while (!taken) begin
                @(negedge clk);
                taken = s_payload_tready;
                // Matched beats only stall on a full FIFO
                if (!taken && row_echo[i]) begin
                    fifo_full_seen = 1'b1;
                end
                @(posedge clk);
                #1;
            end
        end
        s_payload_tvalid = 1'b0;
        s_payload_tlast  = 1'b0;
    endtask

    task automatic run_source();
        int i;
        for (i = 0; i < ROWS; i++) begin
            send_header(i);
            send_payload(i);
        end
    endtask

    task automatic run_sink();
        ip_addr_t      e_ip;
        udp_port_t     e_sport;
        udp_port_t     e_dport;
        udp_len_t      e_len;
        payload_word_t e_data;
        payload_keep_t e_keep;
        logic          e_last;
        logic          e_user;
        logic          first;
        logic          led_pending;
        led_t          e_led;
        first       = 1'b1;
        led_pending = 1'b0;
        e_led       = '0;
        forever begin
            @(posedge clk);
            #1;
            m_hdr_ready = ($urandom % 10) < 7;
            // Payload output stays blocked until the FIFO has filled once
            if (fifo_full_seen) begin
                m_payload_tready = ($urandom % 10) < 7;
            end else begin
                m_payload_tready = 1'b0;
            end
            @(negedge clk);
            // LED settles one edge after the last beat of a frame
            if (led_pending) begin
                led_pending = 1'b0;
                if (led !== e_led) begin
                    errors++;
                    $display("Mismatch at %0t: led %h, expected %h", $time, led, e_led);
                end
            end
            if (m_hdr_valid && m_hdr_ready) begin
                if (exp_ip.size() == 0) begin
                    errors++;
                    $display("Reply header at %0t without a matching datagram", $time);
                end else begin
                    e_ip    = exp_ip.pop_front();
                    e_sport = exp_sport.pop_front();
                    e_dport = exp_dport.pop_front();
                    e_len   = exp_len.pop_front();
                    if (m_ip_dest_ip !== e_ip || m_source_port !== e_sport ||
                        m_dest_port !== e_dport || m_length !== e_len) begin
                        errors++;
                        $display("Mismatch at %0t: header %h/%0d/%0d/%0d, expected %h/%0d/%0d/%0d",
                                 $time, m_ip_dest_ip, m_source_port, m_dest_port, m_length,
                                 e_ip, e_sport, e_dport, e_len);
                    end
                end
            end
            if (m_payload_tvalid && m_payload_tready) begin
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("Reply payload word at %0t without a matching datagram", $time);
                end else begin
                    e_data = exp_data.pop_front();
                    e_keep = exp_keep.pop_front();
                    e_last = exp_last.pop_front();
                    e_user = exp_user.pop_front();
                    if (m_payload_tdata !== e_data || m_payload_tkeep !== e_keep ||
                        m_payload_tlast !== e_last || m_payload_tuser !== e_user) begin
                        errors++;
                        $display("Mismatch at %0t: payload %h/%h/%b/%b, expected %h/%h/%b/%b",
                                 $time, m_payload_tdata, m_payload_tkeep, m_payload_tlast,
                                 m_payload_tuser, e_data, e_keep, e_last, e_user);
                    end
                    if (first) begin
                        e_led = e_data[7:0];
                    end
                    first       = e_last;
                    led_pending = e_last;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(24199));
        errors           = 0;
        fifo_full_seen   = 1'b0;
        rst              = 1'b1;
        s_hdr_valid      = 1'b0;
        s_ip_source_ip   = '0;
        s_source_port    = '0;
        s_dest_port      = '0;
        s_length         = '0;
        s_payload_tdata  = '0;
        s_payload_tkeep  = '0;
        s_payload_tvalid = 1'b0;
        s_payload_tlast  = 1'b0;
        s_payload_tuser  = 1'b0;
        m_hdr_ready      = 1'b0;
        m_payload_tready = 1'b0;
        load_table();

        repeat (5) begin
            @(posedge clk);
            #1;
            check_outputs_idle("during reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_outputs_idle("after reset");
        if (s_hdr_ready !== 1'b0 || s_payload_tready !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t: input ready high in first cycle after reset", $time);
        end
        @(posedge clk);
        #1;

        fork
            run_source();
            run_sink();
        join_any

        // Drain the scoreboard, then watch for stray replies
        while (exp_ip.size() != 0 || exp_data.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);

        errors += udp_echo_core_inst.udp_echo_assert_inst.fail_count;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d cycles, %0d headers and %0d words outstanding",
                 CYCLE_LIMIT, exp_ip.size(), exp_data.size());
        $display("Errors: %0d", errors + 1);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: udp_payload_fifo.sv
/*
 * Payload FIFO
 * Circular buffer for payload beats with a registered output stage;
 * a write into an empty FIFO goes straight to the output register
 */

`timescale 1ns/1ps
`default_nettype none

module udp_payload_fifo #(
    parameter int DEPTH = 16
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              wr_valid,
    output logic                             wr_ready,
    input  wire udp_echo_pkg::payload_word_t wr_data,
    input  wire udp_echo_pkg::payload_keep_t wr_keep,
    input  wire                              wr_last,
    input  wire                              wr_user,
    output udp_echo_pkg::payload_word_t      m_payload_tdata,
    output udp_echo_pkg::payload_keep_t      m_payload_tkeep,
    output logic                             m_payload_tvalid,
    input  wire                              m_payload_tready,
    output logic                             m_payload_tlast,
    output logic                             m_payload_tuser
);
    import udp_echo_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);

    payload_word_t mem_data [DEPTH];
    payload_keep_t mem_keep [DEPTH];
    logic          mem_last [DEPTH];
    logic          mem_user [DEPTH];

    // Extra top bit tells full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;

    logic mem_empty;
    logic mem_full;
    logic wr_fire;
    logic out_load;
    logic bypass;
    logic mem_wr;
    logic mem_rd;

    assign mem_empty = wr_ptr == rd_ptr;
    assign mem_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                       (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    assign wr_ready = !mem_full;
    assign wr_fire  = wr_valid && wr_ready;

    // Output register can take a word when empty or being drained
    assign out_load = !m_payload_tvalid || m_payload_tready;
    assign mem_rd   = out_load && !mem_empty;
    assign bypass   = out_load && mem_empty && wr_fire;
    assign mem_wr   = wr_fire && !bypass;

    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem_data[wr_ptr[ADDR_W-1:0]] <= wr_data;
            mem_keep[wr_ptr[ADDR_W-1:0]] <= wr_keep;
            mem_last[wr_ptr[ADDR_W-1:0]] <= wr_last;
            mem_user[wr_ptr[ADDR_W-1:0]] <= wr_user;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            m_payload_tvalid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (out_load) begin
                m_payload_tvalid <= mem_rd || bypass;
            end
        end
    end

    // Output payload register, older words in memory go first
    always_ff @(posedge clk) begin
        if (mem_rd) begin
            m_payload_tdata <= mem_data[rd_ptr[ADDR_W-1:0]];
            m_payload_tkeep <= mem_keep[rd_ptr[ADDR_W-1:0]];
            m_payload_tlast <= mem_last[rd_ptr[ADDR_W-1:0]];
            m_payload_tuser <= mem_user[rd_ptr[ADDR_W-1:0]];
        end else if (bypass) begin
            m_payload_tdata <= wr_data;
            m_payload_tkeep <= wr_keep;
            m_payload_tlast <= wr_last;
            m_payload_tuser <= wr_user;
        end
    end

endmodule

`default_nettype wire

// File: udp_port_filter.sv
/*
 * UDP port filter
 * Matches each datagram against the echo port, hands matched headers to
 * the reply builder and steers the payload to the FIFO or discards it
 */

`timescale 1ns/1ps
`default_nettype none

`include "udp_echo_cfg.svh"

module udp_port_filter (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              s_hdr_valid,
    output logic                             s_hdr_ready,
    input  wire udp_echo_pkg::ip_addr_t      s_ip_source_ip,
    input  wire udp_echo_pkg::udp_port_t     s_source_port,
    input  wire udp_echo_pkg::udp_port_t     s_dest_port,
    input  wire udp_echo_pkg::udp_len_t      s_length,
    input  wire udp_echo_pkg::payload_word_t s_payload_tdata,
    input  wire udp_echo_pkg::payload_keep_t s_payload_tkeep,
    input  wire                              s_payload_tvalid,
    output logic                             s_payload_tready,
    input  wire                              s_payload_tlast,
    input  wire                              s_payload_tuser,
    output logic                             reply_req,
    input  wire                              reply_ack,
    output logic [31:0]                      reply_ip_dest_ip,
    output logic [15:0]                      reply_source_port,
    output logic [15:0]                      reply_dest_port,
    output logic [15:0]                      reply_length,
    output logic                             wr_valid,
    input  wire                              wr_ready,
    output udp_echo_pkg::payload_word_t      wr_data,
    output udp_echo_pkg::payload_keep_t      wr_keep,
    output logic                             wr_last,
    output logic                             wr_user
);
    import udp_echo_pkg::*;

    localparam udp_port_t ECHO_PORT = udp_port_t'(`UDP_ECHO_PORT);

    typedef enum logic [1:0] {st_idle, st_match, st_drop} state_t;

    state_t state;
    logic   live;
    logic   dest_match;
    logic   hdr_fire;
    logic   beat_fire;

    assign dest_match = s_dest_port == ECHO_PORT;

    // Matched headers wait for the builder, others are taken at once
    assign s_hdr_ready = live && state == st_idle && (dest_match ? reply_ack : 1'b1);
    assign reply_req   = s_hdr_valid && live && state == st_idle && dest_match;
    assign hdr_fire    = s_hdr_valid && s_hdr_ready;

    // Reply goes back to the sender with the ports swapped
    assign reply_ip_dest_ip  = s_ip_source_ip;
    assign reply_source_port = s_dest_port;
    assign reply_dest_port   = s_source_port;
    assign reply_length      = s_length;

    // Payload steering
    assign s_payload_tready = (state == st_match) ? wr_ready : (state == st_drop);
    assign beat_fire        = s_payload_tvalid && s_payload_tready;
    assign wr_valid         = s_payload_tvalid && state == st_match;
    assign wr_data          = s_payload_tdata;
    assign wr_keep          = s_payload_tkeep;
    assign wr_last          = s_payload_tlast;
    assign wr_user          = s_payload_tuser;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            live  <= 1'b0;
        end else begin
            // Header path opens one cycle after reset
            live <= 1'b1;
            case (state)
                st_idle: begin
                    if (hdr_fire) begin
                        state <= dest_match ? st_match : st_drop;
                    end
                end
                default: begin
                    if (beat_fire && s_payload_tlast) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: udp_reply_builder.sv
/*
 * Reply builder
 * Holds one outgoing reply header and captures the low byte of the
 * first payload word of each reply frame for the LEDs
 */

`timescale 1ns/1ps
`default_nettype none

module udp_reply_builder (
    input  wire                              clk,
    input  wire                              rst,
    input  wire                              reply_req,
    output logic                             reply_ack,
    input  wire udp_echo_pkg::ip_addr_t      reply_ip_dest_ip,
    input  wire udp_echo_pkg::udp_port_t     reply_source_port,
    input  wire udp_echo_pkg::udp_port_t     reply_dest_port,
    input  wire udp_echo_pkg::udp_len_t      reply_length,
    output logic                             m_hdr_valid,
    input  wire                              m_hdr_ready,
    output udp_echo_pkg::ip_addr_t           m_ip_dest_ip,
    output udp_echo_pkg::udp_port_t          m_source_port,
    output udp_echo_pkg::udp_port_t          m_dest_port,
    output udp_echo_pkg::udp_len_t           m_length,
    input  wire                              m_payload_tvalid,
    input  wire                              m_payload_tready,
    input  wire                              m_payload_tlast,
    input  wire udp_echo_pkg::payload_word_t m_payload_tdata,
    output udp_echo_pkg::led_t               led
);
    logic req_fire;
    logic beat_fire;
    logic first_beat;

    // Register free, or emptied in this same cycle
    assign reply_ack = !m_hdr_valid || m_hdr_ready;
    assign req_fire  = reply_req && reply_ack;
    assign beat_fire = m_payload_tvalid && m_payload_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_hdr_valid <= 1'b0;
        end else if (req_fire) begin
            m_hdr_valid <= 1'b1;
        end else if (m_hdr_ready) begin
            m_hdr_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            m_ip_dest_ip  <= reply_ip_dest_ip;
            m_source_port <= reply_source_port;
            m_dest_port   <= reply_dest_port;
            m_length      <= reply_length;
        end
    end

    // Frame boundary tracking on the outgoing payload
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (beat_fire) begin
            first_beat <= m_payload_tlast;
            if (first_beat) begin
                led <= m_payload_tdata[7:0];
            end
        end
    end

endmodule

`default_nettype wire
